//--- include/core_macros.svh
/* Core sizes. CORE_NUM_REGS stays at 32 because register indices
   are five bits. INSTR_CREDITS must be at least 2, and credit_cnt_t
   has to hold RETIRE_CREDITS. */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Datapath and register file
`define CORE_XLEN 32
`define CORE_NUM_REGS 32

// Decode input buffer depth, also the upstream credits after reset
`define INSTR_CREDITS 2

// Entries in the consumer's retire buffer
`define RETIRE_CREDITS 4

// Retire order counter
`define ORDER_WIDTH 64

`endif

//--- hw/core_isa_pkg.sv
/* RV32I encodings for the OP and OP-IMM classes only.
   Loads, stores, branches and system opcodes are not decoded. */
`default_nettype none
`include "core_macros.svh"

package core_isa_pkg;

  typedef logic [`CORE_XLEN-1:0] word_t;
  typedef logic [31:0]           insn_t;
  typedef logic [4:0]            reg_addr_t;

  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011
  } opcode_e;

  // funct3 field
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // funct7 field, alt selects SUB and SRA
  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_e;

endpackage

`default_nettype wire

//--- hw/core_pipe_pkg.sv
/* Payloads carried between the pipeline stages.
   The write flag is already cleared for illegal instructions. */
`default_nettype none
`include "core_macros.svh"

package core_pipe_pkg;

  typedef logic [`ORDER_WIDTH-1:0] order_t;

  // Counts 0 to RETIRE_CREDITS
  typedef logic [2:0] credit_cnt_t;

  // Decode to execute
  typedef struct packed {
    core_isa_pkg::alu_op_e   alu_op;
    core_isa_pkg::word_t     op_a;
    core_isa_pkg::word_t     op_b;
    core_isa_pkg::reg_addr_t rd;
    logic                    we;
    logic                    illegal;
    core_isa_pkg::insn_t     insn;
  } decoded_op_t;

  // Execute to result
  typedef struct packed {
    core_isa_pkg::reg_addr_t rd;
    logic                    we;
    logic                    illegal;
    core_isa_pkg::insn_t     insn;
    core_isa_pkg::word_t     value;
  } exec_result_t;

endpackage

`default_nettype wire

//--- hw/credit_chan_if.sv
/* Single-credit channel. valid is a one-cycle pulse and spends the
   sender's credit, credit is a one-cycle pulse once the item is used. */
`timescale 1ns/100ps
`default_nettype none

interface credit_chan_if #(
  parameter type payload_t = logic
);

  logic     valid;
  payload_t payload;
  logic     credit;

  modport sender (
    output valid,
    output payload,
    input  credit
  );

  modport receiver (
    input  valid,
    input  payload,
    output credit
  );

endinterface

`default_nettype wire

//--- hw/register_file.sv
/* Two combinational read ports, one write port. x0 reads zero
   and ignores writes, so it has no storage. */
`timescale 1ns/100ps
`default_nettype none
`include "core_macros.svh"

module register_file (
  input  logic                    clk,
  input  logic                    rst_ni,
  input  core_isa_pkg::reg_addr_t raddr_a_i,
  input  core_isa_pkg::reg_addr_t raddr_b_i,
  output core_isa_pkg::word_t     rdata_a_o,
  output core_isa_pkg::word_t     rdata_b_o,
  input  logic                    we_i,
  input  core_isa_pkg::reg_addr_t waddr_i,
  input  core_isa_pkg::word_t     wdata_i
);
  import core_isa_pkg::*;

  word_t regs_q [1:`CORE_NUM_REGS-1];

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < `CORE_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // x0 is hardwired
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

`default_nettype wire

//--- hw/decode_stage.sv
/* Buffers up to INSTR_CREDITS instructions and issues the head in order.
   Issue waits on a pending source or destination register, so each
   register has at most one write in flight. */
`timescale 1ns/100ps
`default_nettype none
`include "core_macros.svh"

module decode_stage (
  input  logic                    clk,
  input  logic                    rst_ni,
  input  logic                    instr_valid_i,
  input  core_isa_pkg::insn_t     instr_i,
  output logic                    instr_credit_o,
  output core_isa_pkg::reg_addr_t rf_raddr_a_o,
  output core_isa_pkg::reg_addr_t rf_raddr_b_o,
  input  core_isa_pkg::word_t     rf_rdata_a_i,
  input  core_isa_pkg::word_t     rf_rdata_b_i,
  input  logic                    wb_we_i,
  input  core_isa_pkg::reg_addr_t wb_waddr_i,
  credit_chan_if.sender           dec2ex
);
  import core_isa_pkg::*;
  import core_pipe_pkg::*;

  localparam int unsigned ptr_w = $clog2(`INSTR_CREDITS);
  localparam int unsigned cnt_w = $clog2(`INSTR_CREDITS + 1);

  insn_t                     fifo_q [`INSTR_CREDITS];
  logic [ptr_w-1:0]          wr_ptr_q;
  logic [ptr_w-1:0]          rd_ptr_q;
  logic [cnt_w-1:0]          count_q;
  logic [`CORE_NUM_REGS-1:0] pend_q;
  logic [`CORE_NUM_REGS-1:0] pend_d;
  logic                      cred_q;

  insn_t       head;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  reg_addr_t   rs1;
  reg_addr_t   rs2;
  reg_addr_t   rd;
  alu_op_e     alu_op;
  logic        is_op;
  logic        illegal;
  logic        hazard;
  logic        issue;
  decoded_op_t op_d;

  //////////////////////////////////////////////////////////////////////
  // Input buffer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (instr_valid_i) begin
      fifo_q[wr_ptr_q] <= instr_i;
    end
  end

  assign head   = fifo_q[rd_ptr_q];
  assign funct3 = head[14:12];
  assign funct7 = head[31:25];
  assign rs1    = head[19:15];
  assign rs2    = head[24:20];
  assign rd     = head[11:7];
  assign is_op  = (head[6:0] == opc_op);

  //////////////////////////////////////////////////////////////////////
  // Decoder
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    alu_op  = alu_add;
    illegal = 1'b0;
    case (head[6:0])
      opc_op: begin
        case ({funct7, funct3})
          {f7_base, f3_add}:  alu_op = alu_add;
          {f7_alt,  f3_add}:  alu_op = alu_sub;
          {f7_base, f3_sll}:  alu_op = alu_sll;
          {f7_base, f3_slt}:  alu_op = alu_slt;
          {f7_base, f3_sltu}: alu_op = alu_sltu;
          {f7_base, f3_xor}:  alu_op = alu_xor;
          {f7_base, f3_sr}:   alu_op = alu_srl;
          {f7_alt,  f3_sr}:   alu_op = alu_sra;
          {f7_base, f3_or}:   alu_op = alu_or;
          {f7_base, f3_and}:  alu_op = alu_and;
          default:            illegal = 1'b1;
        endcase
      end
      opc_op_imm: begin
        case (funct3)
          f3_add:  alu_op = alu_add;
          f3_slt:  alu_op = alu_slt;
          f3_sltu: alu_op = alu_sltu;
          f3_xor:  alu_op = alu_xor;
          f3_or:   alu_op = alu_or;
          f3_and:  alu_op = alu_and;
          // Shift immediates keep a funct7 in the upper bits
          f3_sll: begin
            alu_op  = alu_sll;
            illegal = (funct7 != f7_base);
          end
          default: begin
            alu_op  = (funct7 == f7_alt) ? alu_sra : alu_srl;
            illegal = (funct7 != f7_base) && (funct7 != f7_alt);
          end
        endcase
      end
      default: illegal = 1'b1;
    endcase
  end

  // Operand b is rs2 for OP, the sign-extended immediate for OP-IMM
  assign rf_raddr_a_o = rs1;
  assign rf_raddr_b_o = rs2;
  assign op_d = '{
    alu_op:  alu_op,
    op_a:    rf_rdata_a_i,
    op_b:    is_op ? rf_rdata_b_i : {{(`CORE_XLEN-12){head[31]}}, head[31:20]},
    rd:      rd,
    we:      !illegal,
    illegal: illegal,
    insn:    head
  };

  //////////////////////////////////////////////////////////////////////
  // Scoreboard and issue
  //////////////////////////////////////////////////////////////////////

  assign hazard         = pend_q[rs1] | (is_op & pend_q[rs2]) | pend_q[rd];
  assign issue          = (count_q != '0) & cred_q & ~hazard;
  assign instr_credit_o = issue;

  // A new claim on the same register wins over the write-back
  always_comb begin
    pend_d = pend_q;
    if (wb_we_i) begin
      pend_d[wb_waddr_i] = 1'b0;
    end
    if (issue && op_d.we && rd != '0) begin
      pend_d[rd] = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      count_q      <= '0;
      pend_q       <= '0;
      cred_q       <= 1'b1;
      dec2ex.valid <= 1'b0;
    end else begin
      if (instr_valid_i) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(`INSTR_CREDITS - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (issue) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(`INSTR_CREDITS - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q      <= count_q + cnt_w'(instr_valid_i) - cnt_w'(issue);
      pend_q       <= pend_d;
      cred_q       <= (cred_q & ~issue) | dec2ex.credit;
      dec2ex.valid <= issue;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      dec2ex.payload <= op_d;
    end
  end

  // Upstream only sends against a free entry
  assert property (@(posedge clk) disable iff (!rst_ni)
    instr_valid_i |-> count_q != cnt_w'(`INSTR_CREDITS));

  // No second item before execute has handed the credit back
  assert property (@(posedge clk) disable iff (!rst_ni)
    dec2ex.valid && !dec2ex.credit |=> !dec2ex.valid until_with dec2ex.credit);

endmodule

`default_nettype wire

//--- hw/execute_stage.sv
/* One-cycle ALU. An item that arrives without an ex2res credit is
   held, and its dec2ex credit is returned only once it moves on. */
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
  input  logic              clk,
  input  logic              rst_ni,
  credit_chan_if.receiver   dec2ex,
  credit_chan_if.sender     ex2res
);
  import core_isa_pkg::*;
  import core_pipe_pkg::*;

  decoded_op_t held_q;
  decoded_op_t cur;
  logic        hold_q;
  logic        cred_q;
  logic        cur_valid;
  logic        fire;
  logic [4:0]  shamt;
  word_t       alu_res;

  // The held item takes the place of a new arrival
  assign cur           = hold_q ? held_q : dec2ex.payload;
  assign cur_valid     = hold_q | dec2ex.valid;
  assign fire          = cur_valid & cred_q;
  assign dec2ex.credit = fire;
  assign shamt         = cur.op_b[4:0];

  always_comb begin
    case (cur.alu_op)
      alu_add:  alu_res = cur.op_a + cur.op_b;
      alu_sub:  alu_res = cur.op_a - cur.op_b;
      alu_sll:  alu_res = cur.op_a << shamt;
      alu_slt:  alu_res = word_t'($signed(cur.op_a) < $signed(cur.op_b));
      alu_sltu: alu_res = word_t'(cur.op_a < cur.op_b);
      alu_xor:  alu_res = cur.op_a ^ cur.op_b;
      alu_srl:  alu_res = cur.op_a >> shamt;
      alu_sra:  alu_res = word_t'($signed(cur.op_a) >>> shamt);
      alu_or:   alu_res = cur.op_a | cur.op_b;
      alu_and:  alu_res = cur.op_a & cur.op_b;
      default:  alu_res = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_q       <= 1'b0;
      cred_q       <= 1'b1;
      ex2res.valid <= 1'b0;
    end else begin
      hold_q       <= cur_valid & ~fire;
      cred_q       <= (cred_q & ~fire) | ex2res.credit;
      ex2res.valid <= fire;
    end
  end

  always_ff @(posedge clk) begin
    if (cur_valid && !fire) begin
      held_q <= cur;
    end
    if (fire) begin
      ex2res.payload <= '{
        rd:      cur.rd,
        we:      cur.we,
        illegal: cur.illegal,
        insn:    cur.insn,
        value:   alu_res
      };
    end
  end

  // Decode waits for the credit, so a held item is never overrun
  assert property (@(posedge clk) disable iff (!rst_ni) dec2ex.valid |-> !hold_q);

endmodule

`default_nettype wire

//--- hw/result_stage.sv
/* Writes back and retires in order. The consumer must not return more
   than RETIRE_CREDITS credits. retire_order_o counts completed retires. */
`timescale 1ns/100ps
`default_nettype none
`include "core_macros.svh"

module result_stage (
  input  logic                    clk,
  input  logic                    rst_ni,
  credit_chan_if.receiver         ex2res,
  output logic                    rf_we_o,
  output core_isa_pkg::reg_addr_t rf_waddr_o,
  output core_isa_pkg::word_t     rf_wdata_o,
  output logic                    retire_valid_o,
  output core_pipe_pkg::order_t   retire_order_o,
  output core_isa_pkg::insn_t     retire_insn_o,
  output logic                    retire_trap_o,
  output core_isa_pkg::reg_addr_t retire_rd_addr_o,
  output core_isa_pkg::word_t     retire_rd_wdata_o,
  input  logic                    retire_credit_i
);
  import core_isa_pkg::*;
  import core_pipe_pkg::*;

  exec_result_t held_q;
  exec_result_t cur;
  logic         hold_q;
  logic         cur_valid;
  logic         accept;
  logic         writes;
  credit_cnt_t  cnt_q;

  assign cur           = hold_q ? held_q : ex2res.payload;
  assign cur_valid     = hold_q | ex2res.valid;
  assign accept        = cur_valid & (cnt_q != '0);
  assign ex2res.credit = accept;

  // x0 and illegal words leave the register file alone
  assign writes     = cur.we & (cur.rd != '0);
  assign rf_we_o    = accept & writes;
  assign rf_waddr_o = cur.rd;
  assign rf_wdata_o = cur.value;

  //////////////////////////////////////////////////////////////////////
  // Retire credits and order
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_q         <= 1'b0;
      cnt_q          <= credit_cnt_t'(`RETIRE_CREDITS);
      retire_valid_o <= 1'b0;
      retire_order_o <= '0;
    end else begin
      hold_q         <= cur_valid & ~accept;
      retire_valid_o <= accept;
      retire_order_o <= retire_order_o + order_t'(retire_valid_o);
      case ({accept, retire_credit_i})
        2'b10:   cnt_q <= cnt_q - 1'b1;
        2'b01:   cnt_q <= cnt_q + 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cur_valid && !accept) begin
      held_q <= cur;
    end
    if (accept) begin
      retire_insn_o     <= cur.insn;
      retire_trap_o     <= cur.illegal;
      retire_rd_addr_o  <= writes ? cur.rd : '0;
      retire_rd_wdata_o <= writes ? cur.value : '0;
    end
  end

  // Consumer returns no more than it was given
  assert property (@(posedge clk) disable iff (!rst_ni)
    cnt_q <= credit_cnt_t'(`RETIRE_CREDITS));

endmodule

`default_nettype wire

//--- hw/core_top.sv
/* Three-stage OP/OP-IMM core. Both ports use credits: upstream starts
   with INSTR_CREDITS, the core starts with RETIRE_CREDITS. */
`timescale 1ns/100ps
`default_nettype none

module core_top (
  input  logic                    clk,
  input  logic                    rst_ni,
  input  logic                    instr_valid_i,
  input  core_isa_pkg::insn_t     instr_i,
  output logic                    instr_credit_o,
  output logic                    retire_valid_o,
  output core_pipe_pkg::order_t   retire_order_o,
  output core_isa_pkg::insn_t     retire_insn_o,
  output logic                    retire_trap_o,
  output core_isa_pkg::reg_addr_t retire_rd_addr_o,
  output core_isa_pkg::word_t     retire_rd_wdata_o,
  input  logic                    retire_credit_i
);
  import core_isa_pkg::*;
  import core_pipe_pkg::*;

  reg_addr_t rf_raddr_a;
  reg_addr_t rf_raddr_b;
  word_t     rf_rdata_a;
  word_t     rf_rdata_b;
  logic      rf_we;
  reg_addr_t rf_waddr;
  word_t     rf_wdata;

  credit_chan_if #(.payload_t(decoded_op_t))  dec2ex ();
  credit_chan_if #(.payload_t(exec_result_t)) ex2res ();

  //////////////////////////////////////////////////////////////////////
  // Stages
  //////////////////////////////////////////////////////////////////////

  decode_stage u_decode (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .instr_credit_o (instr_credit_o),
    .rf_raddr_a_o   (rf_raddr_a),
    .rf_raddr_b_o   (rf_raddr_b),
    .rf_rdata_a_i   (rf_rdata_a),
    .rf_rdata_b_i   (rf_rdata_b),
    .wb_we_i        (rf_we),
    .wb_waddr_i     (rf_waddr),
    .dec2ex         (dec2ex.sender)
  );

  execute_stage u_execute (
    .clk    (clk),
    .rst_ni (rst_ni),
    .dec2ex (dec2ex.receiver),
    .ex2res (ex2res.sender)
  );

  result_stage u_result (
    .clk               (clk),
    .rst_ni            (rst_ni),
    .ex2res            (ex2res.receiver),
    .rf_we_o           (rf_we),
    .rf_waddr_o        (rf_waddr),
    .rf_wdata_o        (rf_wdata),
    .retire_valid_o    (retire_valid_o),
    .retire_order_o    (retire_order_o),
    .retire_insn_o     (retire_insn_o),
    .retire_trap_o     (retire_trap_o),
    .retire_rd_addr_o  (retire_rd_addr_o),
    .retire_rd_wdata_o (retire_rd_wdata_o),
    .retire_credit_i   (retire_credit_i)
  );

  // Write-back also clears the decode scoreboard
  register_file u_regfile (
    .clk       (clk),
    .rst_ni    (rst_ni),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b),
    .we_i      (rf_we),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata)
  );

endmodule

`default_nettype wire

//--- test/tb_clock.sv
/* Free-running 10 ns clock. Reset is held low for the first
   two rising edges and released after them. */
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire

//--- test/tb_core.sv
/* Random OP and OP-IMM program with illegal words and x0 writes.
   Registers x0 to x7 only, so hazards between neighbours are common.
   Retires are checked in program order against a model register file. */
`timescale 1ns/100ps
`default_nettype none
`include "core_macros.svh"

module tb_core;
  import core_isa_pkg::*;
  import core_pipe_pkg::*;

  localparam int num_insns  = 200;
  localparam int watchdog_ns = 20 * num_insns * 10;

  logic      clk;
  logic      rst_ni;
  logic      instr_valid_i = 1'b0;
  insn_t     instr_i = '0;
  logic      instr_credit_o;
  logic      retire_valid_o;
  order_t    retire_order_o;
  insn_t     retire_insn_o;
  logic      retire_trap_o;
  reg_addr_t retire_rd_addr_o;
  word_t     retire_rd_wdata_o;
  logic      retire_credit_i = 1'b0;

  insn_t prog [num_insns];
  word_t model_regs [32];
  int    sent;
  int    credit_pulses;
  int    icredits;
  int    avail;
  int    outstanding;
  int    freeable;
  int    ret_idx = 0;
  int    value_errors = 0;
  int    protocol_errors = 0;

  tb_clock u_tb_clock (
    .clk_o  (clk),
    .rst_no (rst_ni)
  );

  core_top u_core_top (
    .clk               (clk),
    .rst_ni            (rst_ni),
    .instr_valid_i     (instr_valid_i),
    .instr_i           (instr_i),
    .instr_credit_o    (instr_credit_o),
    .retire_valid_o    (retire_valid_o),
    .retire_order_o    (retire_order_o),
    .retire_insn_o     (retire_insn_o),
    .retire_trap_o     (retire_trap_o),
    .retire_rd_addr_o  (retire_rd_addr_o),
    .retire_rd_wdata_o (retire_rd_wdata_o),
    .retire_credit_i   (retire_credit_i)
  );

  //////////////////////////////////////////////////////////////////////
  // Program generation and reference rules
  //////////////////////////////////////////////////////////////////////

  function automatic insn_t gen_insn(input int idx, input reg_addr_t prev_rd);
    logic [2:0]  f3;
    logic [11:0] imm;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    insn_t       word;
    int          kind;
    f3   = 3'($urandom);
    rd   = 5'($urandom_range(0, 7));
    rs1  = ($urandom_range(0, 1) != 0) ? prev_rd : 5'($urandom_range(0, 7));
    rs2  = 5'($urandom_range(0, 7));
    imm  = 12'($urandom);
    kind = $urandom_range(0, 9);
    // Seed x1 to x7 with ADDI first
    if (idx < 7) begin
      return {imm, 5'd0, 3'b000, 5'(idx + 1), 7'b0010011};
    end
    if (kind < 4) begin
      return {((f3 == 3'b000 || f3 == 3'b101) && $urandom_range(0, 1) != 0) ? 7'h20 : 7'h00,
              rs2, rs1, f3, rd, 7'b0110011};
    end
    if (kind < 8) begin
      if (f3 == 3'b001) begin
        imm[11:5] = 7'h00;
      end else if (f3 == 3'b101) begin
        imm[11:5] = ($urandom_range(0, 1) != 0) ? 7'h20 : 7'h00;
      end
      return {imm, rs1, f3, rd, 7'b0010011};
    end
    // MUL-class funct7 is not decoded, nor are loads and branches
    if (kind == 8) begin
      return {7'h01, rs2, rs1, f3, rd, 7'b0110011};
    end
    word      = $urandom;
    word[6:0] = idx[0] ? 7'b0000011 : 7'b1100011;
    return word;
  endfunction

  function automatic logic insn_legal(input insn_t insn);
    logic [6:0] f7;
    logic [2:0] f3;
    f7 = insn[31:25];
    f3 = insn[14:12];
    if (insn[6:0] == 7'b0110011) begin
      return f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
    end
    if (insn[6:0] == 7'b0010011) begin
      if (f3 == 3'b001) return f7 == 7'h00;
      if (f3 == 3'b101) return f7 == 7'h00 || f7 == 7'h20;
      return 1'b1;
    end
    return 1'b0;
  endfunction

  // Bit 5 of the opcode separates OP from OP-IMM, bit 30 picks SUB and SRA
  function automatic word_t alu_ref(input insn_t insn, input word_t a, input word_t b);
    case (insn[14:12])
      3'b000:  return (insn[30] && insn[5]) ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101:  return insn[30] ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic check_retire();
    insn_t exp_insn;
    word_t op_b;
    word_t value;
    logic  legal;
    logic  writes;
    exp_insn = prog[ret_idx];
    legal    = insn_legal(exp_insn);
    writes   = legal && exp_insn[11:7] != 5'd0;
    op_b     = exp_insn[5] ? model_regs[exp_insn[24:20]] : {{20{exp_insn[31]}}, exp_insn[31:20]};
    value    = alu_ref(exp_insn, model_regs[exp_insn[19:15]], op_b);
    assert (retire_insn_o == exp_insn) else begin
      $display("error %0t: retire %0d insn %h, expected %h", $time, ret_idx,
               retire_insn_o, exp_insn);
      value_errors++;
    end
    assert (retire_order_o == order_t'(ret_idx)) else begin
      $display("error %0t: order %0d, expected %0d", $time, retire_order_o, ret_idx);
      value_errors++;
    end
    assert (retire_trap_o == !legal) else begin
      $display("error %0t: insn %h trap %b, expected %b", $time, exp_insn, retire_trap_o, !legal);
      value_errors++;
    end
    assert (retire_rd_addr_o == (writes ? exp_insn[11:7] : 5'd0)) else begin
      $display("error %0t: insn %h rd %0d, expected %0d", $time, exp_insn, retire_rd_addr_o,
               writes ? exp_insn[11:7] : 5'd0);
      value_errors++;
    end
    assert (retire_rd_wdata_o == (writes ? value : '0)) else begin
      $display("error %0t: insn %h data %h, expected %h", $time, exp_insn, retire_rd_wdata_o,
               writes ? value : '0);
      value_errors++;
    end
    if (writes) begin
      model_regs[exp_insn[11:7]] = value;
    end
    ret_idx++;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sender, consumer and retire monitor
  //////////////////////////////////////////////////////////////////////

  // A credit pulse seen at this edge may be spent right away
  always @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_i <= 1'b0;
      icredits      <= `INSTR_CREDITS;
      sent          <= 0;
      credit_pulses <= 0;
    end else begin
      avail = icredits + int'(instr_credit_o);
      if (instr_credit_o) credit_pulses <= credit_pulses + 1;
      if (avail > 0 && sent < num_insns && $urandom_range(0, 3) != 0) begin
        instr_valid_i <= 1'b1;
        instr_i       <= prog[sent];
        sent          <= sent + 1;
        icredits      <= avail - 1;
      end else begin
        instr_valid_i <= 1'b0;
        icredits      <= avail;
      end
    end
  end

  // Consumer frees one entry now and then
  always @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      retire_credit_i <= 1'b0;
      outstanding     <= 0;
    end else begin
      freeable = outstanding + int'(retire_valid_o);
      if (freeable > 0 && $urandom_range(0, 2) == 0) begin
        retire_credit_i <= 1'b1;
        outstanding     <= freeable - 1;
      end else begin
        retire_credit_i <= 1'b0;
        outstanding     <= freeable;
      end
    end
  end

  always @(posedge clk) begin
    if (rst_ni && retire_valid_o) begin
      if (ret_idx < num_insns) begin
        check_retire();
      end else begin
        $display("retire seen after the last instruction already retired");
        protocol_errors++;
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rst_ni)
    retire_valid_o |-> outstanding < `RETIRE_CREDITS)
  else begin
    $display("retire valid raised with no retire credit left at %0t", $time);
    protocol_errors++;
  end

  assert property (@(posedge clk) disable iff (!rst_ni)
    instr_credit_o |-> credit_pulses < sent)
  else begin
    $display("instruction credit returned for an instruction never sent at %0t", $time);
    protocol_errors++;
  end

  //////////////////////////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h1fa3_7932));
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    for (int i = 0; i < num_insns; i++) begin
      prog[i] = gen_insn(i, (i > 0) ? prog[i-1][11:7] : 5'd0);
    end
    wait (ret_idx == num_insns);
    repeat (4) @(posedge clk);
    if (credit_pulses != num_insns) begin
      $display("only %0d instruction credits came back for %0d instructions",
               credit_pulses, num_insns);
      protocol_errors++;
    end
    $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired with %0d of %0d instructions retired", ret_idx, num_insns);
    $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+include
hw/core_isa_pkg.sv
hw/core_pipe_pkg.sv
hw/credit_chan_if.sv
hw/register_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/core_top.sv
test/tb_clock.sv
test/tb_core.sv

//--- Bender.yml
package:
  name: core_pipe

export_include_dirs:
  - include

sources:
  - files:
      - hw/core_isa_pkg.sv
      - hw/core_pipe_pkg.sv
      - hw/credit_chan_if.sv
      - hw/register_file.sv
      - hw/decode_stage.sv
      - hw/execute_stage.sv
      - hw/result_stage.sv
      - hw/core_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/tb_core.sv
